/* src/mpu_settings.svh */
`ifndef MPU_SETTINGS_SVH
`define MPU_SETTINGS_SVH

// ===========================================================================
// address windows, compared against adr[31:12]
// ===========================================================================

// programmable interval timer
`define MPU_PIT_BASE 20'hFF960

// interrupt controller
`define MPU_PIC_BASE 20'hFF9C0

// ===========================================================================
// sizing
// ===========================================================================

// timer channels, 1 to 3; channel n drives interrupt source 29+n
`define MPU_PIT_CHANNELS 3

// external interrupt inputs, sources 1 to 28
`define MPU_IRQ_SOURCES 28

`endif

/* src/mpu_pkg.sv */
`default_nettype none

package mpu_pkg;

	// ========================================================================
	// bus controller
	// ========================================================================

	// target of a captured request
	typedef enum logic [1:0] {
		REG_PIT,
		REG_PIC,
		REG_EXT
	} region_e;

	// request sequence
	// idle -> busy (target strobe up) -> ack (one cycle) -> done (one cycle)
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_ACK,
		ST_DONE
	} bus_state_e;

	// ========================================================================
	// interrupt controller
	// ========================================================================

	// number of the highest enabled pending source, zero when none
	typedef logic [7:0] cause_t;

endpackage

`default_nettype wire

/* src/mpu_bus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mpu_settings.svh"

module mpu_bus_ctrl
	import mpu_pkg::*;
(
	input  wire           clk_i,
	input  wire           rst_i,
	// processor side
	input  wire           cyc_i,
	input  wire           stb_i,
	input  wire           we_i,
	input  wire  [15:0]   sel_i,
	input  wire  [31:0]   adr_i,
	input  wire  [127:0]  dat_i,
	output logic [127:0]  dat_o,
	output logic          ack_o,
	output logic          err_o,
	// registered request, shared by peripherals and external bus
	output logic          pit_stb_o,
	output logic          pic_stb_o,
	output logic          rq_we_o,
	output logic [15:0]   rq_sel_o,
	output logic [31:0]   rq_adr_o,
	output logic [127:0]  rq_dat_o,
	input  wire           pit_ack_i,
	input  wire           pic_ack_i,
	input  wire  [127:0]  loc_dat_i,
	// external bus
	output logic          xcyc_o,
	output logic          xstb_o,
	input  wire  [127:0]  xdat_i,
	input  wire           xack_i,
	input  wire           xerr_i
);

	bus_state_e state;
	region_e    rgn;
	region_e    dec_rgn;
	logic       fin_ack;
	logic       fin_err;

	// address decode on the upper 20 bits, anything else goes off chip
	always_comb begin
		if (adr_i[31:12] == `MPU_PIT_BASE)
			dec_rgn = REG_PIT;
		else if (adr_i[31:12] == `MPU_PIC_BASE)
			dec_rgn = REG_PIC;
		else
			dec_rgn = REG_EXT;
	end

	// completion of the current target
	// only the external bus can return an error
	always_comb begin
		fin_ack = 1'b0;
		fin_err = 1'b0;
		case (rgn)
		REG_PIT: fin_ack = pit_ack_i;
		REG_PIC: fin_ack = pic_ack_i;
		default: begin
			fin_ack = xack_i;
			fin_err = xerr_i & ~xack_i;
		end
		endcase
	end

	// ========================================================================
	// request FSM
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state     <= ST_IDLE;
			rgn       <= REG_EXT;
			ack_o     <= 1'b0;
			err_o     <= 1'b0;
			pit_stb_o <= 1'b0;
			pic_stb_o <= 1'b0;
			xcyc_o    <= 1'b0;
			xstb_o    <= 1'b0;
		end else begin
			case (state)
			ST_IDLE: begin
				// one strobe per request, raised on the capture edge
				if (cyc_i && stb_i) begin
					rgn       <= dec_rgn;
					pit_stb_o <= (dec_rgn == REG_PIT);
					pic_stb_o <= (dec_rgn == REG_PIC);
					xcyc_o    <= (dec_rgn == REG_EXT);
					xstb_o    <= (dec_rgn == REG_EXT);
					state     <= ST_BUSY;
				end
			end
			ST_BUSY: begin
				// no timeout, an external slave may stall forever
				if (fin_ack || fin_err) begin
					ack_o     <= fin_ack;
					err_o     <= fin_err;
					pit_stb_o <= 1'b0;
					pic_stb_o <= 1'b0;
					xcyc_o    <= 1'b0;
					xstb_o    <= 1'b0;
					state     <= ST_ACK;
				end
			end
			ST_ACK: begin
				ack_o <= 1'b0;
				err_o <= 1'b0;
				state <= ST_DONE;
			end
			// master drops stb here, so stb_i is not looked at
			default: state <= ST_IDLE;
			endcase
		end
	end

	// request and response payload
	always_ff @(posedge clk_i) begin
		if (state == ST_IDLE && cyc_i && stb_i) begin
			rq_we_o  <= we_i;
			rq_sel_o <= sel_i;
			rq_adr_o <= adr_i;
			rq_dat_o <= dat_i;
		end
		if (state == ST_BUSY && (fin_ack || fin_err))
			dat_o <= (rgn == REG_EXT) ? xdat_i : loc_dat_i;
	end

endmodule

`default_nettype wire

/* src/mpu_lane_adapt.sv */
`timescale 1ns/1ps
`default_nettype none

module mpu_lane_adapt (
	// registered 128-bit request
	input  wire  [15:0]   rq_sel_i,
	input  wire  [31:0]   rq_adr_i,
	input  wire  [127:0]  rq_dat_i,
	// 32-bit peripheral side
	output logic [31:0]   p_adr_o,
	output logic [3:0]    p_sel_o,
	output logic [31:0]   p_dat_o,
	input  wire  [31:0]   pit_dat_i,
	input  wire  [31:0]   pic_dat_i,
	output logic [127:0]  loc_dat_o
);

	logic [3:0] lane_any;
	logic [1:0] lane;

	// one bit per 32-bit lane with any byte select set
	assign lane_any = {|rq_sel_i[15:12], |rq_sel_i[11:8], |rq_sel_i[7:4], |rq_sel_i[3:0]};

	// single active lane picks address bits 3:2 and the write word
	// multi-lane selects fall back to lane 0
	always_comb begin
		case (lane_any)
		4'b0010: lane = 2'd1;
		4'b0100: lane = 2'd2;
		4'b1000: lane = 2'd3;
		default: lane = 2'd0;
		endcase
	end

	assign p_adr_o = {rq_adr_i[31:4], lane, 2'b00};

	// byte enables of all lanes folded onto one word
	assign p_sel_o = rq_sel_i[15:12] | rq_sel_i[11:8] | rq_sel_i[7:4] | rq_sel_i[3:0];

	assign p_dat_o = rq_dat_i[32*lane +: 32];

	// idle peripherals return zero, so an OR merges them
	// the word shows up in every lane, the processor picks its own
	assign loc_dat_o = {4{pit_dat_i | pic_dat_i}};

endmodule

`default_nettype wire

/* src/mpu_pit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mpu_settings.svh"

module mpu_pit (
	input  wire                          clk_i,
	input  wire                          rst_i,
	input  wire                          stb_i,
	input  wire                          we_i,
	input  wire  [5:0]                   adr_i,
	input  wire  [3:0]                   sel_i,
	input  wire  [31:0]                  dat_i,
	output logic [31:0]                  dat_o,
	output logic                         ack_o,
	output logic [`MPU_PIT_CHANNELS-1:0] tick_o
);

	localparam int CH = `MPU_PIT_CHANNELS;

	logic [31:0]   max_cnt [CH];
	logic [31:0]   cur_cnt [CH];
	logic [CH-1:0] en;
	logic [CH-1:0] ar;
	logic          acc;
	logic          wr;
	logic [31:0]   rd_word;

	// first strobe cycle only, the strobe is still up while ack is out
	assign acc = stb_i & ~ack_o;
	assign wr  = acc & we_i;

	// ========================================================================
	// register read, channel n at offset 16n
	// ========================================================================
	always_comb begin
		rd_word = '0;
		for (int n = 0; n < CH; n++) begin
			if (adr_i[5:4] == 2'(n)) begin
				case (adr_i[3:2])
				2'd0:    rd_word = max_cnt[n];
				2'd1:    rd_word = cur_cnt[n];
				2'd2:    rd_word = {30'd0, ar[n], en[n]};
				default: rd_word = '0;
				endcase
			end
		end
	end

	// one-cycle ack per strobe
	always_ff @(posedge clk_i) begin
		if (rst_i)
			ack_o <= 1'b0;
		else
			ack_o <= acc;
	end

	// read data is zero outside the ack cycle
	always_ff @(posedge clk_i)
		dat_o <= acc ? rd_word : '0;

	// ========================================================================
	// channel control and tick
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			en     <= '0;
			ar     <= '0;
			tick_o <= '0;
		end else begin
			for (int n = 0; n < CH; n++) begin
				tick_o[n] <= 1'b0;
				// terminal count, one-shot channels switch off
				if (en[n] && cur_cnt[n] == 32'd0) begin
					tick_o[n] <= 1'b1;
					en[n]     <= ar[n];
				end
				// a bus write to control wins over the terminal count
				if (wr && adr_i[5:4] == 2'(n) && adr_i[3:2] == 2'd2 && sel_i[0]) begin
					en[n] <= dat_i[0];
					ar[n] <= dat_i[1];
				end
			end
		end
	end

	// counters
	always_ff @(posedge clk_i) begin
		for (int n = 0; n < CH; n++) begin
			if (en[n])
				cur_cnt[n] <= (cur_cnt[n] == 32'd0) ? max_cnt[n] : cur_cnt[n] - 32'd1;
			// max count, byte by byte
			if (wr && adr_i[5:4] == 2'(n) && adr_i[3:2] == 2'd0) begin
				for (int b = 0; b < 4; b++) begin
					if (sel_i[b])
						max_cnt[n][8*b +: 8] <= dat_i[8*b +: 8];
				end
			end
			// setting enable starts from max count
			if (wr && adr_i[5:4] == 2'(n) && adr_i[3:2] == 2'd2 && sel_i[0] && dat_i[0])
				cur_cnt[n] <= max_cnt[n];
		end
	end

endmodule

`default_nettype wire

/* src/mpu_pic.sv */
`timescale 1ns/1ps
`default_nettype none

module mpu_pic
	import mpu_pkg::*;
(
	input  wire          clk_i,
	input  wire          rst_i,
	input  wire          stb_i,
	input  wire          we_i,
	input  wire  [3:0]   adr_i,
	input  wire  [31:0]  dat_i,
	output logic [31:0]  dat_o,
	output logic         ack_o,
	// interrupt sources, 0 does not exist
	input  wire  [31:1]  src_i,
	output logic [2:0]   irq_o,
	output cause_t       cause_o
);

	logic [31:1] src_q;
	logic [31:0] enable;
	logic [31:0] pending;
	logic [31:0] rise;
	logic [31:0] clr;
	logic [31:0] act;
	logic [2:0]  level;
	logic        acc;
	logic        wr;
	logic [31:0] rd_word;
	cause_t      enc;

	assign acc = stb_i & ~ack_o;
	assign wr  = acc & we_i;

	// rising edges, bit 0 stays clear
	assign rise = {src_i & ~src_q, 1'b0};

	// write one to clear on PENDING
	assign clr = (wr && adr_i[3:2] == 2'd1) ? dat_i : '0;

	assign act = pending & enable;

	// highest enabled pending source wins
	always_comb begin
		enc = '0;
		for (int i = 1; i < 32; i++) begin
			if (act[i])
				enc = cause_t'(i);
		end
	end

	// ========================================================================
	// register file
	// ENABLE 0, PENDING 4, LEVEL 8, CAUSE 12
	// ========================================================================
	always_comb begin
		case (adr_i[3:2])
		2'd0:    rd_word = enable;
		2'd1:    rd_word = pending;
		2'd2:    rd_word = {29'd0, level};
		default: rd_word = {24'd0, cause_o};
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			src_q   <= '0;
			enable  <= '0;
			pending <= '0;
			level   <= '0;
			irq_o   <= '0;
			cause_o <= '0;
			ack_o   <= 1'b0;
		end else begin
			src_q <= src_i;
			ack_o <= acc;
			// a new edge beats a clear in the same cycle
			pending <= (pending & ~clr) | rise;
			if (wr && adr_i[3:2] == 2'd0)
				enable <= dat_i;
			if (wr && adr_i[3:2] == 2'd2)
				level <= dat_i[2:0];
			// outputs follow pending by one edge
			irq_o   <= (|act) ? level : 3'd0;
			cause_o <= enc;
		end
	end

	// zero outside the ack cycle
	always_ff @(posedge clk_i)
		dat_o <= acc ? rd_word : '0;

endmodule

`default_nettype wire

/* src/mpu_io.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mpu_settings.svh"

module mpu_io
	import mpu_pkg::*;
(
	input  wire                         clk_i,
	input  wire                         rst_i,
	// processor bus
	input  wire                         cyc_i,
	input  wire                         stb_i,
	input  wire                         we_i,
	input  wire  [15:0]                 sel_i,
	input  wire  [31:0]                 adr_i,
	input  wire  [127:0]                dat_i,
	output logic [127:0]                dat_o,
	output logic                        ack_o,
	output logic                        err_o,
	// external bus
	output logic                        xcyc_o,
	output logic                        xstb_o,
	output logic                        xwe_o,
	output logic [15:0]                 xsel_o,
	output logic [31:0]                 xadr_o,
	output logic [127:0]                xdat_o,
	input  wire  [127:0]                xdat_i,
	input  wire                         xack_i,
	input  wire                         xerr_i,
	// interrupts
	input  wire  [`MPU_IRQ_SOURCES-1:0] irq_src_i,
	output logic [2:0]                  irq_o,
	output cause_t                      cause_o
);

	logic                         pit_stb;
	logic                         pic_stb;
	logic                         rq_we;
	logic [15:0]                  rq_sel;
	logic [31:0]                  rq_adr;
	logic [127:0]                 rq_dat;
	logic                         pit_ack;
	logic                         pic_ack;
	logic [127:0]                 loc_dat;
	logic [31:0]                  p_adr;
	logic [3:0]                   p_sel;
	logic [31:0]                  p_dat;
	logic [31:0]                  pit_dat;
	logic [31:0]                  pic_dat;
	logic [`MPU_PIT_CHANNELS-1:0] tick;
	logic [31:1]                  pic_src;

	// ========================================================================
	// request capture and routing
	// ========================================================================
	mpu_bus_ctrl u_ctrl (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.we_i      (we_i),
		.sel_i     (sel_i),
		.adr_i     (adr_i),
		.dat_i     (dat_i),
		.dat_o     (dat_o),
		.ack_o     (ack_o),
		.err_o     (err_o),
		.pit_stb_o (pit_stb),
		.pic_stb_o (pic_stb),
		.rq_we_o   (rq_we),
		.rq_sel_o  (rq_sel),
		.rq_adr_o  (rq_adr),
		.rq_dat_o  (rq_dat),
		.pit_ack_i (pit_ack),
		.pic_ack_i (pic_ack),
		.loc_dat_i (loc_dat),
		.xcyc_o    (xcyc_o),
		.xstb_o    (xstb_o),
		.xdat_i    (xdat_i),
		.xack_i    (xack_i),
		.xerr_i    (xerr_i)
	);

	// external bus carries the registered request as is
	assign xwe_o  = rq_we;
	assign xsel_o = rq_sel;
	assign xadr_o = rq_adr;
	assign xdat_o = rq_dat;

	mpu_lane_adapt u_lane (
		.rq_sel_i  (rq_sel),
		.rq_adr_i  (rq_adr),
		.rq_dat_i  (rq_dat),
		.p_adr_o   (p_adr),
		.p_sel_o   (p_sel),
		.p_dat_o   (p_dat),
		.pit_dat_i (pit_dat),
		.pic_dat_i (pic_dat),
		.loc_dat_o (loc_dat)
	);

	// ========================================================================
	// peripherals
	// ========================================================================
	mpu_pit u_pit (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.stb_i  (pit_stb),
		.we_i   (rq_we),
		.adr_i  (p_adr[5:0]),
		.sel_i  (p_sel),
		.dat_i  (p_dat),
		.dat_o  (pit_dat),
		.ack_o  (pit_ack),
		.tick_o (tick)
	);

	// timer channel n on source 29+n, missing channels read as zero
	assign pic_src = {3'(tick), irq_src_i};

	mpu_pic u_pic (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.stb_i   (pic_stb),
		.we_i    (rq_we),
		.adr_i   (p_adr[3:0]),
		.dat_i   (p_dat),
		.dat_o   (pic_dat),
		.ack_o   (pic_ack),
		.src_i   (pic_src),
		.irq_o   (irq_o),
		.cause_o (cause_o)
	);

endmodule

`default_nettype wire

/* bench/mpu_io_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module mpu_io_chk
	import mpu_pkg::*;
(
	input wire        clk_i,
	input wire        rst_i,
	input wire        ack_o,
	input wire        err_o,
	input wire        pit_stb_o,
	input wire        pic_stb_o,
	input wire        xstb_o,
	input bus_state_e state
);

	// ack is a single-cycle pulse
	a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |=> !ack_o)
		else $error("ack_o high for two cycles");

	a_ack_err: assert property (@(posedge clk_i) disable iff (rst_i)
		!(ack_o && err_o))
		else $error("ack_o and err_o high together");

	// the done cycle starts nothing on the following edge
	a_done_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
		(state == ST_DONE) |=> !(pit_stb_o || pic_stb_o || xstb_o))
		else $error("strobe raised in the done state");

endmodule

bind mpu_bus_ctrl mpu_io_chk u_chk (
	.clk_i     (clk_i),
	.rst_i     (rst_i),
	.ack_o     (ack_o),
	.err_o     (err_o),
	.pit_stb_o (pit_stb_o),
	.pic_stb_o (pic_stb_o),
	.xstb_o    (xstb_o),
	.state     (state)
);

`default_nettype wire

/* bench/mpu_io_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mpu_settings.svh"

module mpu_io_tb
	import mpu_pkg::*;
;

	// ========================================================================
	// row kinds of the operation table
	// ========================================================================
	localparam int K_WR   = 0;
	localparam int K_RD   = 1;
	localparam int K_WAIT = 2;
	localparam int K_SRC  = 3;
	localparam int K_IRQ  = 4;
	localparam int K_XERR = 5;
	localparam int K_SLOW = 6;

	// byte selects of the four 32-bit lanes
	localparam logic [15:0] L0 = 16'h000F;
	localparam logic [15:0] L1 = 16'h00F0;
	localparam logic [15:0] L2 = 16'h0F00;
	localparam logic [15:0] L3 = 16'hF000;

	localparam logic [31:0] PIT = 32'hFF96_0000;
	localparam logic [31:0] PIC = 32'hFF9C_0000;

	typedef struct {
		string        name;
		int           kind;
		logic [31:0]  adr;
		logic [15:0]  sel;
		logic [127:0] dat;
		logic [127:0] exp;
	} row_t;

	logic                         clk_i;
	logic                         rst_i;
	logic                         cyc_i;
	logic                         stb_i;
	logic                         we_i;
	logic [15:0]                  sel_i;
	logic [31:0]                  adr_i;
	logic [127:0]                 dat_i;
	logic [127:0]                 dat_o;
	logic                         ack_o;
	logic                         err_o;
	logic                         xcyc_o;
	logic                         xstb_o;
	logic                         xwe_o;
	logic [15:0]                  xsel_o;
	logic [31:0]                  xadr_o;
	logic [127:0]                 xdat_o;
	logic [127:0]                 xdat_i;
	logic                         xack_i;
	logic                         xerr_i;
	logic [`MPU_IRQ_SOURCES-1:0]  irq_src_i;
	logic [2:0]                   irq_o;
	cause_t                       cause_o;

	row_t         rows[$];
	int           errors;
	int           cycles;
	int           limit;
	logic [15:0]  lfsr;
	// request as issued for the responder to compare against
	logic         cur_we;
	logic [15:0]  cur_sel;
	logic [31:0]  cur_adr;
	logic [127:0] cur_dat;
	logic         resp_err;
	int           forced_delay;

	mpu_io UUT (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.we_i      (we_i),
		.sel_i     (sel_i),
		.adr_i     (adr_i),
		.dat_i     (dat_i),
		.dat_o     (dat_o),
		.ack_o     (ack_o),
		.err_o     (err_o),
		.xcyc_o    (xcyc_o),
		.xstb_o    (xstb_o),
		.xwe_o     (xwe_o),
		.xsel_o    (xsel_o),
		.xadr_o    (xadr_o),
		.xdat_o    (xdat_o),
		.xdat_i    (xdat_i),
		.xack_i    (xack_i),
		.xerr_i    (xerr_i),
		.irq_src_i (irq_src_i),
		.irq_o     (irq_o),
		.cause_o   (cause_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// ========================================================================
	// helpers
	// ========================================================================

	// 16-bit Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// word returned by the external slave in every lane
	function automatic logic [127:0] slave_word(input logic [31:0] a);
		slave_word = {4{a ^ 32'hA5A5_0F0F}};
	endfunction

	function automatic logic is_external(input logic [31:0] a);
		is_external = (a[31:12] != `MPU_PIT_BASE) && (a[31:12] != `MPU_PIC_BASE);
	endfunction

	task automatic check_value(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		if (act !== exp) begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic add_row(input string n, input int k, input logic [31:0] a,
		input logic [15:0] s, input logic [127:0] d, input logic [127:0] e);
		row_t r;
		r.name = n;
		r.kind = k;
		r.adr  = a;
		r.sel  = s;
		r.dat  = d;
		r.exp  = e;
		rows.push_back(r);
	endtask

	// ========================================================================
	// external slave with a random 0 to 7 cycle delay unless forced
	// ========================================================================
	initial begin
		logic [2:0] d;
		int         n;
		xack_i <= 1'b0;
		xerr_i <= 1'b0;
		xdat_i <= '0;
		forever begin
			@(negedge clk_i);
			if (xstb_o) begin
				check_value("xcyc", 128'(1'b1), 128'(xcyc_o));
				check_value("xwe", 128'(cur_we), 128'(xwe_o));
				check_value("xsel", 128'(cur_sel), 128'(xsel_o));
				check_value("xadr", 128'(cur_adr), 128'(xadr_o));
				check_value("xdat", cur_dat, xdat_o);
				d = '0;
				for (int i = 0; i < 3; i++) begin
					d    = {d[1:0], lfsr[0]};
					lfsr = lfsr_next(lfsr);
				end
				n = (forced_delay > 0) ? forced_delay : int'(d);
				repeat (n) @(posedge clk_i);
				@(posedge clk_i);
				xack_i <= ~resp_err;
				xerr_i <= resp_err;
				xdat_i <= resp_err ? '0 : slave_word(xadr_o);
				@(posedge clk_i);
				xack_i <= 1'b0;
				xerr_i <= 1'b0;
				xdat_i <= '0;
			end
		end
	end

	// run limit from the table length
	always @(posedge clk_i) begin
		cycles++;
		if (limit != 0 && cycles >= limit) begin
			$display("timeout: no bus response within %0d cycles", limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// one processor bus request that returns at the negedge where ack_o or err_o is seen
	task automatic bus_access(input row_t r, input logic wr, input logic want_err);
		int   edges;
		logic ext;
		ext     = is_external(r.adr);
		cur_we  = wr;
		cur_sel = r.sel;
		cur_adr = r.adr;
		cur_dat = r.dat;
		edges   = 0;
		@(posedge clk_i);
		cyc_i <= 1'b1;
		stb_i <= 1'b1;
		we_i  <= wr;
		sel_i <= r.sel;
		adr_i <= r.adr;
		dat_i <= r.dat;
		forever begin
			@(posedge clk_i);
			edges++;
			@(negedge clk_i);
			if (ack_o || err_o)
				break;
			// the external strobe must hold until the slave answers
			if (ext && !xstb_o) begin
				$display("%s: external strobe dropped before the slave answered", r.name);
				errors++;
			end
		end
		check_value({r.name, " ack"}, 128'(!want_err), 128'(ack_o));
		check_value({r.name, " err"}, 128'(want_err), 128'(err_o));
		// local access completes on the third edge
		if (!ext)
			check_value({r.name, " latency"}, 128'd3, 128'(edges));
		if (!wr && !want_err)
			check_value(r.name, r.exp, dat_o);
		@(posedge clk_i);
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
	endtask

	task automatic run_row(input row_t r);
		int e0;
		e0 = errors;
		case (r.kind)
		K_WR: bus_access(r, 1'b1, 1'b0);
		K_RD: bus_access(r, 1'b0, 1'b0);
		K_XERR: begin
			resp_err = 1'b1;
			bus_access(r, 1'b0, 1'b1);
			resp_err = 1'b0;
		end
		K_SLOW: begin
			forced_delay = 30;
			bus_access(r, 1'b0, 1'b0);
			forced_delay = 0;
		end
		K_WAIT: begin
			repeat (int'(r.dat)) @(posedge clk_i);
			@(negedge clk_i);
		end
		K_SRC: begin
			@(posedge clk_i);
			irq_src_i <= r.dat[`MPU_IRQ_SOURCES-1:0];
			@(negedge clk_i);
		end
		default: check_value(r.name, r.exp, 128'({cause_o, irq_o}));
		endcase
		$display("%s: %s", r.name, (errors == e0) ? "ok" : "mismatch");
	endtask

	// ========================================================================
	// operation table
	// ========================================================================
	task automatic build_table();
		// register access through every lane
		add_row("pit max ch1 write lane0", K_WR, PIT + 32'h10, L0, 128'h1234_5678, '0);
		add_row("pit max ch1 read lane0", K_RD, PIT + 32'h10, L0, '0, {4{32'h1234_5678}});
		add_row("pit count ch1 write lane1", K_WR, PIT + 32'h10, L1, 128'hFFFF_0000 << 32, '0);
		add_row("pit max ch1 unchanged", K_RD, PIT + 32'h10, L0, '0, {4{32'h1234_5678}});
		add_row("pit max ch1 byte write", K_WR, PIT + 32'h10, 16'h0001, 128'hAB, '0);
		add_row("pit max ch1 byte read", K_RD, PIT + 32'h10, L0, '0, {4{32'h1234_56AB}});
		add_row("pit ctrl ch2 write lane2", K_WR, PIT + 32'h20, L2, 128'h2 << 64, '0);
		add_row("pit ctrl ch2 read lane2", K_RD, PIT + 32'h20, L2, '0, {4{32'h2}});
		// the other lanes carry words that a wrong lane decode would store
		add_row("pit spare ch2 write lane3", K_WR, PIT + 32'h20, L3,
			{32'hDEAD_BEEF, 32'h3, 32'h7777, 32'h5555}, '0);
		add_row("pit spare ch2 read lane3", K_RD, PIT + 32'h20, L3, '0, '0);
		// one-shot channel 0 with max count 5
		add_row("pit max ch0 write", K_WR, PIT, L0, 128'd5, '0);
		add_row("pit ctrl ch0 one-shot", K_WR, PIT, L2, 128'h1 << 64, '0);
		add_row("pic pending before terminal", K_RD, PIC, L1, '0, '0);
		add_row("wait one-shot", K_WAIT, '0, '0, 128'd10, '0);
		add_row("pic pending one-shot", K_RD, PIC, L1, '0, {4{32'h2000_0000}});
		add_row("pit ctrl ch0 disabled", K_RD, PIT, L2, '0, '0);
		add_row("pic clear one-shot", K_WR, PIC, L1, 128'h2000_0000 << 32, '0);
		add_row("wait after one-shot", K_WAIT, '0, '0, 128'd12, '0);
		add_row("pic pending stays clear", K_RD, PIC, L1, '0, '0);
		// auto-reload channel 1 with max count 3
		add_row("pit max ch1 write 3", K_WR, PIT + 32'h10, L0, 128'd3, '0);
		add_row("pit ctrl ch1 auto-reload", K_WR, PIT + 32'h10, L2, 128'h3 << 64, '0);
		add_row("wait auto-reload", K_WAIT, '0, '0, 128'd10, '0);
		add_row("pic pending auto-reload", K_RD, PIC, L1, '0, {4{32'h4000_0000}});
		add_row("pic clear auto-reload", K_WR, PIC, L1, 128'h4000_0000 << 32, '0);
		add_row("wait reload again", K_WAIT, '0, '0, 128'd10, '0);
		add_row("pic pending reload again", K_RD, PIC, L1, '0, {4{32'h4000_0000}});
		add_row("pit ctrl ch1 stop", K_WR, PIT + 32'h10, L2, '0, '0);
		add_row("wait after stop", K_WAIT, '0, '0, 128'd4, '0);
		add_row("pic clear after stop", K_WR, PIC, L1, 128'h4000_0000 << 32, '0);
		add_row("pic pending all clear", K_RD, PIC, L1, '0, '0);
		// external sources 5 and 12 at level 6
		add_row("pic enable 5 and 12", K_WR, PIC, L0, 128'h1020, '0);
		add_row("pic level write", K_WR, PIC, L2, 128'h6 << 64, '0);
		add_row("pic level read", K_RD, PIC, L2, '0, {4{32'h6}});
		add_row("raise sources 5 and 12", K_SRC, '0, '0, 128'h810, '0);
		add_row("wait sources", K_WAIT, '0, '0, 128'd4, '0);
		add_row("irq level and cause", K_IRQ, '0, '0, '0, 128'((12 << 3) | 6));
		add_row("pic cause read", K_RD, PIC, L3, '0, {4{32'd12}});
		add_row("pic clear sources", K_WR, PIC, L1, 128'h1020 << 32, '0);
		add_row("wait clear", K_WAIT, '0, '0, 128'd3, '0);
		add_row("irq after clear", K_IRQ, '0, '0, '0, '0);
		// external bus
		add_row("ext write", K_WR, 32'h4000_1000, 16'h00FF, {4{32'h0123_4567}}, '0);
		add_row("ext read a", K_RD, 32'h4000_2040, 16'hFFFF, '0, slave_word(32'h4000_2040));
		add_row("ext read b", K_RD, 32'h0000_0100, 16'h0F00, '0, slave_word(32'h0000_0100));
		add_row("ext read error", K_XERR, 32'h4000_3000, 16'hFFFF, '0, '0);
		add_row("ext read stalled", K_SLOW, 32'h4000_4000, 16'hFFFF, '0,
			slave_word(32'h4000_4000));
		add_row("ext read c", K_RD, 32'hFF97_0000, 16'h000F, '0, slave_word(32'hFF97_0000));
	endtask

	initial begin
		errors       = 0;
		cycles       = 0;
		limit        = 0;
		lfsr         = 16'd6249;
		resp_err     = 1'b0;
		forced_delay = 0;
		rst_i     <= 1'b1;
		cyc_i     <= 1'b0;
		stb_i     <= 1'b0;
		we_i      <= 1'b0;
		sel_i     <= '0;
		adr_i     <= '0;
		dat_i     <= '0;
		irq_src_i <= '0;
		build_table();
		limit = rows.size() * 40;
		repeat (3) @(posedge clk_i);
		rst_i <= 1'b0;
		@(negedge clk_i);
		foreach (rows[i])
			run_row(rows[i]);
		$display("tests %0d errors %0d", rows.size(), errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+src
src/mpu_pkg.sv
src/mpu_bus_ctrl.sv
src/mpu_lane_adapt.sv
src/mpu_pit.sv
src/mpu_pic.sv
src/mpu_io.sv
bench/mpu_io_chk.sv
bench/mpu_io_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mpu_io_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= compile.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +%,$(shell cat $(FLIST))) src/mpu_settings.svh
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
